//--- files.f
design/tracker_pkg.sv
design/camera_pixel_rx.sv
design/pixel_threshold.sv
design/serial_divider.sv
design/centroid_tracker.sv
design/camera_tracker_top.sv
tb/tracker_checker.sv
tb/tracker_monitor.sv
tb/tb_camera_tracker.sv

//--- Bender.yml
package:
  name: camera_tracker

sources:
  - design/tracker_pkg.sv
  - design/camera_pixel_rx.sv
  - design/pixel_threshold.sv
  - design/serial_divider.sv
  - design/centroid_tracker.sv
  - design/camera_tracker_top.sv
  - target: simulation
    files:
      - tb/tracker_checker.sv
      - tb/tracker_monitor.sv
      - tb/tb_camera_tracker.sv

//--- tb/tb_camera_tracker.sv
`timescale 1ns/1ps

module tb_camera_tracker;
  import tracker_pkg::*;

  // camera bus timing in clk_camera cycles
  localparam int PCLK_HALF  = 4;
  localparam int LEAD       = 8;
  localparam int HS_LEAD    = 4;
  localparam int LINE_BLANK = 8;
  localparam int BLANK      = 64;
  // frame size range
  localparam int W_MIN      = 4;
  localparam int W_MAX      = 16;
  localparam int H_MIN      = 2;
  localparam int H_MAX      = 8;
  localparam int NUM_RANDOM = 16;
  // three directed frames ahead of the random ones
  localparam int NUM_FRAMES = NUM_RANDOM + 3;
  // two bytes per pixel, one full pclk period per byte
  localparam int MAX_FRAME_CYCLES =
    LEAD + H_MAX * (HS_LEAD + W_MAX * 4 * PCLK_HALF + LINE_BLANK) + BLANK;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * MAX_FRAME_CYCLES + 1000;

  logic         clk_camera;
  logic         recent_reset;
  logic         cam_pclk;
  logic         cam_hsync;
  logic         cam_vsync;
  cam_byte_t    cam_data;
  channel_sel_e channel_sel;
  channel_t     lower_bound;
  channel_t     upper_bound;
  hcount_t      com_x;
  vcount_t      com_y;
  logic         com_valid;

  int           mon_tests;
  int           mon_errors;
  int           mon_pending;
  integer       seed;
  int           cycle_count;
  int           total_errors;
  int           k;
  pixel_t       fill;
  channel_t     lo;
  channel_t     hi;

  camera_tracker_top u_camera_tracker_top (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .cam_data_i    (cam_data),
    .channel_sel_i (channel_sel),
    .lower_bound_i (lower_bound),
    .upper_bound_i (upper_bound),
    .com_x_o       (com_x),
    .com_y_o       (com_y),
    .com_valid_o   (com_valid)
  );

  tracker_monitor u_tracker_monitor (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .cam_data_i    (cam_data),
    .channel_sel_i (channel_sel),
    .lower_bound_i (lower_bound),
    .upper_bound_i (upper_bound),
    .com_x_i       (com_x),
    .com_y_i       (com_y),
    .com_valid_i   (com_valid),
    .tests_o       (mon_tests),
    .errors_o      (mon_errors),
    .pending_o     (mon_pending)
  );

  initial begin
    clk_camera = 1'b0;
    forever #2 clk_camera = ~clk_camera;
  end

  // inputs change 1 ns after the rising edge
  task automatic tick(input int n);
    repeat (n) @(posedge clk_camera);
    #1;
  endtask

  function automatic int rand_between(input int lo_v, input int hi_v);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo_v + (r % (hi_v - lo_v + 1));
  endfunction

  // data is set up with pclk low, taken on the rising pclk
  task automatic send_byte(input cam_byte_t b);
    cam_pclk = 1'b0;
    cam_data = b;
    tick(PCLK_HALF);
    cam_pclk = 1'b1;
    tick(PCLK_HALF);
  endtask

  task automatic send_frame(input int w, input int h, input channel_sel_e sel,
                            input channel_t lo_b, input channel_t hi_b,
                            input bit uniform, input pixel_t fill_pix);
    int ln;
    int px;
    pixel_t p;
    // settings change in vsync blanking, before any pixel of the frame
    channel_sel = sel;
    lower_bound = lo_b;
    upper_bound = hi_b;
    cam_vsync = 1'b0;
    tick(LEAD);
    for (ln = 0; ln < h; ln++) begin
      cam_hsync = 1'b1;
      tick(HS_LEAD);
      for (px = 0; px < w; px++) begin
        p = uniform ? fill_pix : pixel_t'($random(seed));
        send_byte(p[15:8]);
        send_byte(p[7:0]);
      end
      cam_pclk = 1'b0;
      cam_hsync = 1'b0;
      tick(LINE_BLANK);
    end
    // frame end, long enough for the dividers to finish
    cam_vsync = 1'b1;
    tick(BLANK);
  endtask

  // hard stop if the frames never drain
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_camera);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    seed = 67;
    recent_reset = 1'b1;
    cam_pclk = 1'b0;
    cam_hsync = 1'b0;
    cam_vsync = 1'b0;
    cam_data = '0;
    channel_sel = CH_RED;
    lower_bound = '0;
    upper_bound = '0;
    repeat (4) @(posedge clk_camera);
    #1;
    recent_reset = 1'b0;
    tick(8);

    // lower above upper, nothing masked, outputs stay at reset value
    send_frame(rand_between(W_MIN, W_MAX), rand_between(H_MIN, H_MAX), CH_GREEN,
               8'd200, 8'd100, 1'b0, '0);
    // uniform red with both bounds on the value, gives the geometric centre
    fill = pixel_t'($random(seed));
    send_frame(rand_between(W_MIN, W_MAX), rand_between(H_MIN, H_MAX), CH_RED,
               {fill[15:11], 3'b000}, {fill[15:11], 3'b000}, 1'b1, fill);
    // empty again, previous centre must be held
    send_frame(rand_between(W_MIN, W_MAX), rand_between(H_MIN, H_MAX), CH_BLUE,
               8'd1, 8'd0, 1'b0, '0);

    // red, green, blue, luma in turn with random bounds
    for (k = 0; k < NUM_RANDOM; k++) begin
      lo = channel_t'(rand_between(0, 191));
      // lower bound tops out at 191, so the window never passes 255
      hi = channel_t'(int'(lo) + rand_between(16, 64));
      send_frame(rand_between(W_MIN, W_MAX), rand_between(H_MIN, H_MAX),
                 channel_sel_e'(k % 4), lo, hi, 1'b0, '0);
    end

    while (mon_pending != 0) begin
      tick(1);
    end
    tick(4);

    total_errors = mon_errors
                 + int'(u_camera_tracker_top.u_centroid.u_tracker_checker.fail_count);
    if (mon_tests != NUM_FRAMES) begin
      $display("only %0d of %0d frames were checked", mon_tests, NUM_FRAMES);
    end
    $display("tests %0d of %0d, monitor errors %0d, assertion failures %0d",
             mon_tests, NUM_FRAMES, mon_errors,
             u_camera_tracker_top.u_centroid.u_tracker_checker.fail_count);
    if ((total_errors == 0) && (mon_tests == NUM_FRAMES)) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tb/tracker_monitor.sv
`timescale 1ns/1ps

module tracker_monitor (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  logic                      cam_pclk_i,
  input  logic                      cam_hsync_i,
  input  logic                      cam_vsync_i,
  input  tracker_pkg::cam_byte_t    cam_data_i,
  input  tracker_pkg::channel_sel_e channel_sel_i,
  input  tracker_pkg::channel_t     lower_bound_i,
  input  tracker_pkg::channel_t     upper_bound_i,
  input  tracker_pkg::hcount_t      com_x_i,
  input  tracker_pkg::vcount_t      com_y_i,
  input  logic                      com_valid_i,
  output int                        tests_o,
  output int                        errors_o,
  output int                        pending_o
);
  import tracker_pkg::*;

  // vsync pin rise to com_valid: 3 receiver, 1 threshold, 35 tracker
  localparam int LATENCY = 39;

  // previous pin samples for edge detection
  logic      pclk_q;
  logic      hs_q;
  logic      vs_q;
  // bus decode state
  bit        hi_phase;
  cam_byte_t hi_byte;
  int        col;
  int        line;
  int        value;
  // per frame accumulation
  longint    sum_x;
  longint    sum_y;
  int        count;
  int        cycle;
  int        frame_idx;
  // last result, expected to hold between pulses
  int        held_x;
  int        held_y;
  bit        hold_flagged;
  bit        bad;
  string     test_name;
  // one entry per finished frame, oldest first
  int        q_start[$];
  bit        q_has[$];
  int        q_x[$];
  int        q_y[$];
  int        q_frame[$];
  int        q_chan[$];

  // widen rgb565 by zero padding, luma is (2r + 5g + b) / 8 truncated
  function automatic int channel_value(input pixel_t p, input channel_sel_e sel);
    int r;
    int g;
    int b;
    r = int'(p[15:11]) * 8;
    g = int'(p[10:5]) * 4;
    b = int'(p[4:0]) * 8;
    case (sel)
      CH_RED:   return r;
      CH_GREEN: return g;
      CH_BLUE:  return b;
      default:  return (2 * r + 5 * g + b) / 8;
    endcase
  endfunction

  function automatic string chan_name(input int c);
    case (c)
      0:       return "red";
      1:       return "green";
      2:       return "blue";
      default: return "luma";
    endcase
  endfunction

  task automatic drop_front();
    void'(q_start.pop_front());
    void'(q_has.pop_front());
    void'(q_x.pop_front());
    void'(q_y.pop_front());
    void'(q_frame.pop_front());
    void'(q_chan.pop_front());
    tests_o++;
  endtask

  // sample half a cycle away from both the drive time and the dut edge
  always @(negedge clk_camera) begin
    if (recent_reset) begin
      pclk_q = cam_pclk_i;
      hs_q = cam_hsync_i;
      vs_q = cam_vsync_i;
      hi_phase = 1'b1;
      col = 0;
      line = 0;
      sum_x = 0;
      sum_y = 0;
      count = 0;
      cycle = 0;
      frame_idx = 0;
      held_x = 0;
      held_y = 0;
      hold_flagged = 1'b0;
      tests_o = 0;
      errors_o = 0;
      q_start.delete();
      q_has.delete();
      q_x.delete();
      q_y.delete();
      q_frame.delete();
      q_chan.delete();
    end else begin
      cycle++;
      // bytes pair up on rising pclk while hsync is high, upper half first
      if (!cam_hsync_i) begin
        col = 0;
        hi_phase = 1'b1;
      end else if (cam_pclk_i && !pclk_q) begin
        if (hi_phase) begin
          hi_byte = cam_data_i;
          hi_phase = 1'b0;
        end else begin
          value = channel_value({hi_byte, cam_data_i}, channel_sel_i);
          if ((value >= int'(lower_bound_i)) && (value <= int'(upper_bound_i))) begin
            sum_x += col;
            sum_y += line;
            count++;
          end
          col++;
          hi_phase = 1'b1;
        end
      end
      // line number counts hsync falls, vsync parks it at zero
      if (cam_vsync_i) begin
        line = 0;
      end else if (!cam_hsync_i && hs_q) begin
        line++;
      end
      // rising vsync closes the frame
      if (cam_vsync_i && !vs_q) begin
        q_start.push_back(cycle);
        q_has.push_back(count != 0);
        q_x.push_back((count != 0) ? int'(sum_x / count) : 0);
        q_y.push_back((count != 0) ? int'(sum_y / count) : 0);
        q_frame.push_back(frame_idx);
        q_chan.push_back(int'(channel_sel_i));
        frame_idx++;
        sum_x = 0;
        sum_y = 0;
        count = 0;
      end

      if (com_valid_i) begin
        if (q_start.size() == 0) begin
          $display("com_valid_o pulsed at cycle %0d with no frame waiting", cycle);
          errors_o++;
        end else begin
          test_name = $sformatf("frame %0d %s", q_frame[0], chan_name(q_chan[0]));
          bad = 1'b0;
          if (!q_has[0]) begin
            $display("%s: com_valid_o pulsed for a frame with no masked pixels", test_name);
            bad = 1'b1;
          end else begin
            if (cycle - q_start[0] != LATENCY) begin
              $display("ERR %s latency: expected %0d actual %0d", test_name, LATENCY,
                       cycle - q_start[0]);
              bad = 1'b1;
            end
            if (int'(com_x_i) != q_x[0]) begin
              $display("ERR %s com_x: expected %0d actual %0d", test_name, q_x[0], com_x_i);
              bad = 1'b1;
            end
            if (int'(com_y_i) != q_y[0]) begin
              $display("ERR %s com_y: expected %0d actual %0d", test_name, q_y[0], com_y_i);
              bad = 1'b1;
            end
          end
          if (bad) begin
            errors_o++;
          end else begin
            $display("ok  %s: centre (%0d, %0d)", test_name, com_x_i, com_y_i);
          end
          drop_front();
        end
        held_x = int'(com_x_i);
        held_y = int'(com_y_i);
        hold_flagged = 1'b0;
      end else begin
        // deadline passed without a pulse
        if ((q_start.size() != 0) && (cycle >= q_start[0] + LATENCY)) begin
          test_name = $sformatf("frame %0d %s", q_frame[0], chan_name(q_chan[0]));
          if (q_has[0]) begin
            $display("%s: no com_valid_o within %0d cycles of the frame end",
                     test_name, LATENCY);
            errors_o++;
          end else begin
            $display("ok  %s: no masked pixels, no result", test_name);
          end
          drop_front();
        end
        // outputs keep the last result, 0 after reset
        if (((int'(com_x_i) != held_x) || (int'(com_y_i) != held_y)) && !hold_flagged) begin
          $display("ERR output hold: expected (%0d, %0d) actual (%0d, %0d)",
                   held_x, held_y, com_x_i, com_y_i);
          errors_o++;
          hold_flagged = 1'b1;
        end
      end

      pclk_q = cam_pclk_i;
      hs_q = cam_hsync_i;
      vs_q = cam_vsync_i;
    end
    pending_o = q_start.size();
  end

endmodule

//--- tb/tracker_checker.sv
`timescale 1ns/1ps

module tracker_checker (
  input logic clk_camera,
  input logic recent_reset,
  input logic com_valid_i,
  input logic start_i,
  input logic done_x_i,
  input logic done_y_i
);

  // failures seen so far, read back by the testbench top
  int unsigned fail_count = 0;

  // result strobe lasts a single cycle
  a_com_valid_pulse: assert property (@(posedge clk_camera) disable iff (recent_reset)
    com_valid_i |=> !com_valid_i)
  else begin
    fail_count++;
    $error("com_valid_o stayed high for more than one cycle");
  end

  // shared start, so both dividers report done together 33 cycles later
  a_done_aligned: assert property (@(posedge clk_camera) disable iff (recent_reset)
    start_i |-> ##33 (done_x_i && done_y_i))
  else begin
    fail_count++;
    $error("x and y divider done strobes did not arrive together 33 cycles after start");
  end

  // nothing may come out while reset is held
  a_quiet_in_reset: assert property (@(posedge clk_camera)
    recent_reset |=> !com_valid_i)
  else begin
    fail_count++;
    $error("com_valid_o went high while in reset");
  end

endmodule

bind centroid_tracker tracker_checker u_tracker_checker (
  .clk_camera   (clk_camera),
  .recent_reset (recent_reset),
  .com_valid_i  (com_valid_o),
  .start_i      (div_start),
  .done_x_i     (div_done_x),
  .done_y_i     (div_done_y)
);

//--- design/camera_tracker_top.sv
`timescale 1ns/1ps

module camera_tracker_top (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  logic                      cam_pclk_i,
  input  logic                      cam_hsync_i,
  input  logic                      cam_vsync_i,
  input  tracker_pkg::cam_byte_t    cam_data_i,
  input  tracker_pkg::channel_sel_e channel_sel_i,
  input  tracker_pkg::channel_t     lower_bound_i,
  input  tracker_pkg::channel_t     upper_bound_i,
  output tracker_pkg::hcount_t      com_x_o,
  output tracker_pkg::vcount_t      com_y_o,
  output logic                      com_valid_o
);
  import tracker_pkg::*;

  // receiver to threshold
  logic    pix_valid;
  pixel_t  pix_data;
  hcount_t pix_x;
  vcount_t pix_y;
  logic    rx_frame_end;

  // threshold to tracker
  logic    mask_valid;
  logic    mask_hit;
  hcount_t mask_x;
  vcount_t mask_y;
  logic    mask_frame_end;

  camera_pixel_rx u_pixel_rx (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .cam_data_i   (cam_data_i),
    .pix_valid_o  (pix_valid),
    .pix_data_o   (pix_data),
    .pix_x_o      (pix_x),
    .pix_y_o      (pix_y),
    .frame_end_o  (rx_frame_end)
  );

  pixel_threshold u_threshold (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pix_valid_i   (pix_valid),
    .pix_data_i    (pix_data),
    .pix_x_i       (pix_x),
    .pix_y_i       (pix_y),
    .frame_end_i   (rx_frame_end),
    .channel_sel_i (channel_sel_i),
    .lower_bound_i (lower_bound_i),
    .upper_bound_i (upper_bound_i),
    .mask_valid_o  (mask_valid),
    .mask_hit_o    (mask_hit),
    .mask_x_o      (mask_x),
    .mask_y_o      (mask_y),
    .frame_end_o   (mask_frame_end)
  );

  centroid_tracker u_centroid (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .mask_valid_i (mask_valid),
    .mask_hit_i   (mask_hit),
    .mask_x_i     (mask_x),
    .mask_y_i     (mask_y),
    .frame_end_i  (mask_frame_end),
    .com_x_o      (com_x_o),
    .com_y_o      (com_y_o),
    .com_valid_o  (com_valid_o)
  );

endmodule

//--- design/centroid_tracker.sv
`timescale 1ns/1ps

module centroid_tracker (
  input  logic                 clk_camera,
  input  logic                 recent_reset,
  input  logic                 mask_valid_i,
  input  logic                 mask_hit_i,
  input  tracker_pkg::hcount_t mask_x_i,
  input  tracker_pkg::vcount_t mask_y_i,
  input  logic                 frame_end_i,
  output tracker_pkg::hcount_t com_x_o,
  output tracker_pkg::vcount_t com_y_o,
  output logic                 com_valid_o
);
  import tracker_pkg::*;

  // running totals for the current frame
  sum_t   sum_x_q;
  sum_t   sum_y_q;
  count_t count_q;

  // operands frozen at frame end while the dividers work
  sum_t   dividend_x_q;
  sum_t   dividend_y_q;
  count_t divisor_q;

  logic div_start;
  logic div_busy;
  logic div_done_x;
  logic div_done_y;
  logic both_done;
  sum_t quo_x;
  sum_t quo_y;

  // both dividers see the same start and cycle count, so done lines up
  assign both_done = div_done_x & div_done_y;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      sum_x_q     <= '0;
      sum_y_q     <= '0;
      count_q     <= '0;
      div_start   <= 1'b0;
      div_busy    <= 1'b0;
      com_valid_o <= 1'b0;
      com_x_o     <= '0;
      com_y_o     <= '0;
    end else begin
      div_start   <= 1'b0;
      com_valid_o <= 1'b0;
      if (frame_end_i) begin
        // empty frames and frames ending mid-divide are dropped
        if ((count_q != '0) && !div_busy) begin
          div_start <= 1'b1;
          div_busy  <= 1'b1;
        end
        sum_x_q <= '0;
        sum_y_q <= '0;
        count_q <= '0;
      end else if (mask_valid_i && mask_hit_i) begin
        sum_x_q <= sum_x_q + sum_t'(mask_x_i);
        sum_y_q <= sum_y_q + sum_t'(mask_y_i);
        count_q <= count_q + 1'b1;
      end
      // quotients fit the coordinate range since they are averages
      if (both_done) begin
        div_busy    <= 1'b0;
        com_valid_o <= 1'b1;
        com_x_o     <= hcount_t'(quo_x);
        com_y_o     <= vcount_t'(quo_y);
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (frame_end_i && (count_q != '0) && !div_busy) begin
      dividend_x_q <= sum_x_q;
      dividend_y_q <= sum_y_q;
      divisor_q    <= count_q;
    end
  end

  serial_divider u_div_x (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .start_i      (div_start),
    .dividend_i   (dividend_x_q),
    .divisor_i    (divisor_q),
    .quotient_o   (quo_x),
    .done_o       (div_done_x)
  );

  serial_divider u_div_y (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .start_i      (div_start),
    .dividend_i   (dividend_y_q),
    .divisor_i    (divisor_q),
    .quotient_o   (quo_y),
    .done_o       (div_done_y)
  );

endmodule

//--- design/serial_divider.sv
`timescale 1ns/1ps

module serial_divider (
  input  logic                clk_camera,
  input  logic                recent_reset,
  input  logic                start_i,
  input  tracker_pkg::sum_t   dividend_i,
  input  tracker_pkg::count_t divisor_i,
  output tracker_pkg::sum_t   quotient_o,
  output logic                done_o
);
  import tracker_pkg::*;

  div_state_e state_q;
  // one step per quotient bit
  logic [$clog2(SUM_W)-1:0] step_q;
  // remainder stays below the divisor, one spare bit for the shift
  logic [COUNT_W:0] rem_q;
  logic [COUNT_W:0] rem_shift;
  logic [COUNT_W:0] rem_diff;
  logic             q_bit;
  // dividend shifts out the top while quotient bits shift in below
  sum_t   quo_q;
  count_t div_q;

  assign rem_shift = {rem_q[COUNT_W-1:0], quo_q[SUM_W-1]};
  assign q_bit     = (rem_shift >= {1'b0, div_q});
  assign rem_diff  = rem_shift - {1'b0, div_q};

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state_q <= DIV_IDLE;
      step_q  <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        DIV_IDLE: begin
          if (start_i) begin
            state_q <= DIV_RUN;
            step_q  <= '0;
          end
        end
        default: begin
          step_q <= step_q + 1'b1;
          // last bit lands together with done
          if (int'(step_q) == SUM_W - 1) begin
            state_q <= DIV_IDLE;
            done_o  <= 1'b1;
          end
        end
      endcase
    end
  end

  // datapath, loaded on start and shifted while running
  always_ff @(posedge clk_camera) begin
    if (state_q == DIV_IDLE) begin
      if (start_i) begin
        quo_q <= dividend_i;
        div_q <= divisor_i;
        rem_q <= '0;
      end
    end else begin
      // restore by keeping the shifted value when the trial subtract fails
      rem_q <= q_bit ? rem_diff : rem_shift;
      quo_q <= {quo_q[SUM_W-2:0], q_bit};
    end
  end

  // floor of dividend / divisor, held after done
  assign quotient_o = quo_q;

endmodule

//--- design/pixel_threshold.sv
`timescale 1ns/1ps

module pixel_threshold (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  logic                      pix_valid_i,
  input  tracker_pkg::pixel_t       pix_data_i,
  input  tracker_pkg::hcount_t      pix_x_i,
  input  tracker_pkg::vcount_t      pix_y_i,
  input  logic                      frame_end_i,
  input  tracker_pkg::channel_sel_e channel_sel_i,
  input  tracker_pkg::channel_t     lower_bound_i,
  input  tracker_pkg::channel_t     upper_bound_i,
  output logic                      mask_valid_o,
  output logic                      mask_hit_o,
  output tracker_pkg::hcount_t      mask_x_o,
  output tracker_pkg::vcount_t      mask_y_o,
  output logic                      frame_end_o
);
  import tracker_pkg::*;

  channel_t    red8;
  channel_t    green8;
  channel_t    blue8;
  channel_t    luma8;
  channel_t    chan_sel;
  // 2r + 5g + b tops out at 2004, eleven bits
  logic [10:0] luma_sum;
  logic        hit;

  // widen rgb565 fields by zero padding the low bits
  assign red8   = {pix_data_i[15:11], 3'b000};
  assign green8 = {pix_data_i[10:5], 2'b00};
  assign blue8  = {pix_data_i[4:0], 3'b000};

  assign luma_sum = (11'(red8) << 1) + (11'(green8) * 11'd5) + 11'(blue8);
  // divide by 8, truncated
  assign luma8    = luma_sum[10:3];

  always_comb begin
    case (channel_sel_i)
      CH_RED:   chan_sel = red8;
      CH_GREEN: chan_sel = green8;
      CH_BLUE:  chan_sel = blue8;
      default:  chan_sel = luma8;
    endcase
  end

  // both bounds inclusive
  assign hit = (chan_sel >= lower_bound_i) && (chan_sel <= upper_bound_i);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      mask_valid_o <= 1'b0;
      frame_end_o  <= 1'b0;
    end else begin
      mask_valid_o <= pix_valid_i;
      // same one cycle delay keeps frame end behind the last mask strobe
      frame_end_o  <= frame_end_i;
    end
  end

  always_ff @(posedge clk_camera) begin
    mask_hit_o <= hit;
    mask_x_o   <= pix_x_i;
    mask_y_o   <= pix_y_i;
  end

endmodule

//--- design/camera_pixel_rx.sv
`timescale 1ns/1ps

module camera_pixel_rx (
  input  logic                  clk_camera,
  input  logic                  recent_reset,
  input  logic                  cam_pclk_i,
  input  logic                  cam_hsync_i,
  input  logic                  cam_vsync_i,
  input  tracker_pkg::cam_byte_t cam_data_i,
  output logic                  pix_valid_o,
  output tracker_pkg::pixel_t   pix_data_o,
  output tracker_pkg::hcount_t  pix_x_o,
  output tracker_pkg::vcount_t  pix_y_o,
  output logic                  frame_end_o
);
  import tracker_pkg::*;

  // two sync stages per control line, then a delayed copy for edge detect
  logic pclk_s1;
  logic pclk_s2;
  logic pclk_d;
  logic hs_s1;
  logic hs_s2;
  logic hs_d;
  logic vs_s1;
  logic vs_s2;
  logic vs_d;
  // data only travels alongside pclk, so it gets the same two stages
  cam_byte_t data_s1;
  cam_byte_t data_s2;

  logic pclk_rise;
  logic hs_fall;
  logic vs_rise;

  byte_phase_e phase_q;
  cam_byte_t   hi_byte_q;
  hcount_t     hcount_q;
  vcount_t     vcount_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_s1 <= 1'b0;
      pclk_s2 <= 1'b0;
      pclk_d  <= 1'b0;
      hs_s1   <= 1'b0;
      hs_s2   <= 1'b0;
      hs_d    <= 1'b0;
      vs_s1   <= 1'b0;
      vs_s2   <= 1'b0;
      vs_d    <= 1'b0;
    end else begin
      pclk_s1 <= cam_pclk_i;
      pclk_s2 <= pclk_s1;
      pclk_d  <= pclk_s2;
      hs_s1   <= cam_hsync_i;
      hs_s2   <= hs_s1;
      hs_d    <= hs_s2;
      vs_s1   <= cam_vsync_i;
      vs_s2   <= vs_s1;
      vs_d    <= vs_s2;
    end
  end

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
  end

  assign pclk_rise = pclk_s2 & ~pclk_d;
  assign hs_fall   = ~hs_s2 & hs_d;
  assign vs_rise   = vs_s2 & ~vs_d;

  // byte pairing fsm and the h/v counters
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase_q     <= PH_HIGH;
      hcount_q    <= '0;
      vcount_q    <= '0;
      pix_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      // rising vsync closes the frame
      frame_end_o <= vs_rise;
      if (!hs_s2) begin
        // blanking between lines
        hcount_q <= '0;
        phase_q  <= PH_HIGH;
      end else if (pclk_rise) begin
        if (phase_q == PH_HIGH) begin
          phase_q <= PH_LOW;
        end else begin
          phase_q     <= PH_HIGH;
          pix_valid_o <= 1'b1;
          // saturate at the last supported column
          if (hcount_q < hcount_t'(FRAME_W - 1)) begin
            hcount_q <= hcount_q + 1'b1;
          end
        end
      end
      // vsync holds the line counter at the top of the frame
      if (vs_s2) begin
        vcount_q <= '0;
      end else if (hs_fall && (vcount_q < vcount_t'(FRAME_H - 1))) begin
        vcount_q <= vcount_q + 1'b1;
      end
    end
  end

  // payload, captured with the strobes above
  always_ff @(posedge clk_camera) begin
    if (hs_s2 && pclk_rise) begin
      if (phase_q == PH_HIGH) begin
        hi_byte_q <= data_s2;
      end else begin
        pix_data_o <= {hi_byte_q, data_s2};
        pix_x_o    <= hcount_q;
        pix_y_o    <= vcount_q;
      end
    end
  end

endmodule

//--- design/tracker_pkg.sv
package tracker_pkg;

  // largest frame the pixel counters can address
  localparam int unsigned FRAME_W = 1280;
  localparam int unsigned FRAME_H = 720;

  // accumulator and divider widths
  localparam int unsigned SUM_W   = 32;
  localparam int unsigned COUNT_W = 20;

  // pixel column and line number, sized from the frame limits
  typedef logic [$clog2(FRAME_W)-1:0] hcount_t;
  typedef logic [$clog2(FRAME_H)-1:0] vcount_t;

  // rgb565 pixel as rebuilt from two camera bytes
  typedef logic [15:0] pixel_t;

  // one 8-bit colour channel, also used for the bounds
  typedef logic [7:0] channel_t;

  // raw byte from the camera data pins
  typedef logic [7:0] cam_byte_t;

  // coordinate sums, dividend and quotient
  typedef logic [SUM_W-1:0] sum_t;

  // masked pixel count, also the divisor
  typedef logic [COUNT_W-1:0] count_t;

  // channel fed to the threshold compare
  typedef enum logic [1:0] {
    CH_RED   = 2'd0,
    CH_GREEN = 2'd1,
    CH_BLUE  = 2'd2,
    CH_LUMA  = 2'd3
  } channel_sel_e;

  // which half of the pixel the next camera byte carries
  typedef enum logic {
    PH_HIGH = 1'b0,
    PH_LOW  = 1'b1
  } byte_phase_e;

  // divider fsm
  typedef enum logic {
    DIV_IDLE = 1'b0,
    DIV_RUN  = 1'b1
  } div_state_e;

endpackage
